// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/corePkg.sv
      - logic/pipeLink.sv
      - logic/fetchStage.sv
      - logic/decodeStage.sv
      - logic/executeStage.sv
      - logic/memoryStage.sv
      - logic/mipsCore.sv
  - target: test
    files:
      - bench/wbMemory.sv
      - bench/coreTb.sv

// ==== bench/coreTb.sv ====
`timescale 1ns/1ns

module coreTb;

	localparam int MEM_DEPTH = 64;
	localparam int TAIL_CYCLES = 60; // Quiet time to catch stray stores

	localparam logic [5:0] OP_SPECIAL = 6'd0;
	localparam logic [5:0] OP_J = 6'd2;
	localparam logic [5:0] OP_BEQ = 6'd4;
	localparam logic [5:0] OP_BNE = 6'd5;
	localparam logic [5:0] OP_ADDIU = 6'd9;
	localparam logic [5:0] OP_SLTI = 6'd10;
	localparam logic [5:0] OP_ANDI = 6'd12;
	localparam logic [5:0] OP_ORI = 6'd13;
	localparam logic [5:0] OP_XORI = 6'd14;
	localparam logic [5:0] OP_LUI = 6'd15;
	localparam logic [5:0] OP_LW = 6'd35;
	localparam logic [5:0] OP_SW = 6'd43;
	localparam logic [5:0] FN_SLL = 6'd0;
	localparam logic [5:0] FN_SRL = 6'd2;
	localparam logic [5:0] FN_SRA = 6'd3;
	localparam logic [5:0] FN_ADDU = 6'd33;
	localparam logic [5:0] FN_SUBU = 6'd35;
	localparam logic [5:0] FN_AND = 6'd36;
	localparam logic [5:0] FN_OR = 6'd37;
	localparam logic [5:0] FN_XOR = 6'd38;
	localparam logic [5:0] FN_NOR = 6'd39;
	localparam logic [5:0] FN_SLT = 6'd42;
	localparam logic [5:0] FN_SLTU = 6'd43;

	logic Clk;
	logic rstN;
	logic instCyc, instStb, instAck;
	logic [31:0] instAdr, instDatIn;
	logic dataCyc, dataStb, dataWe, dataAck;
	logic [31:0] dataAdr, dataWrDat, dataRdDat;
	logic storeSeen;
	logic [31:0] storeAdr, storeDat;

	logic [31:0] progWords [$];
	logic [31:0] expAdr [$];
	logic [31:0] expDat [$];
	int cycleCount, cycleLimit, storeTotal;
	int mismatchCount, otherCount;
	logic rstNQ, instOpenQ, dataOpenQ;
	logic [31:0] instAdrQ, dataAdrQ, dataWrDatQ;

	function automatic logic [31:0] rFormat(input logic [5:0] fn, input int rd, input int rs,
			input int rt, input int sa);
		return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
	endfunction

	function automatic logic [31:0] iFormat(input logic [5:0] op, input int rt, input int rs,
			input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] jFormat(input int wordIdx);
		return {OP_J, 26'(wordIdx)};
	endfunction

	task automatic addExpected(input logic [31:0] adr, input logic [31:0] dat);
		expAdr.push_back(adr);
		expDat.push_back(dat);
	endtask

	mipsCore mipsCore_inst (.*);

	wbMemory #(.DEPTH(MEM_DEPTH)) memModel (.*);

	initial Clk = 1'b0;
	always #50 Clk = ~Clk;

	initial begin
		rstN = 1'b0;
		{rstNQ, instOpenQ, dataOpenQ} = 3'b000;
		{instAdrQ, dataAdrQ, dataWrDatQ} = '0;
		{cycleCount, storeTotal, mismatchCount, otherCount} = '0;

		// Immediates, then store each one
		progWords.push_back(iFormat(OP_ORI, 1, 0, 16'h1234));
		progWords.push_back(iFormat(OP_ADDIU, 2, 0, 16'hFFFD));
		progWords.push_back(iFormat(OP_LUI, 3, 0, 16'h8000));
		progWords.push_back(iFormat(OP_ANDI, 4, 2, 16'hF0F0));
		progWords.push_back(iFormat(OP_XORI, 5, 2, 16'h8001));
		progWords.push_back(iFormat(OP_SLTI, 6, 2, 16'hFFFF));
		for (int r = 1; r <= 6; r++)
			progWords.push_back(iFormat(OP_SW, r, 0, 16'((r - 1) * 4)));
		progWords.push_back(rFormat(FN_ADDU, 7, 1, 2, 0));
		progWords.push_back(iFormat(OP_SW, 7, 0, 16'h0018));
		progWords.push_back(rFormat(FN_SUBU, 7, 1, 2, 0));
		progWords.push_back(iFormat(OP_SW, 7, 0, 16'h001C));
		progWords.push_back(rFormat(FN_AND, 7, 5, 4, 0));
		progWords.push_back(iFormat(OP_SW, 7, 0, 16'h0020));
		progWords.push_back(rFormat(FN_OR, 7, 1, 3, 0));
		progWords.push_back(iFormat(OP_SW, 7, 0, 16'h0024));
		progWords.push_back(rFormat(FN_XOR, 7, 1, 2, 0));
		progWords.push_back(iFormat(OP_SW, 7, 0, 16'h0028));
		progWords.push_back(rFormat(FN_NOR, 7, 1, 4, 0));
		progWords.push_back(iFormat(OP_SW, 7, 0, 16'h002C));
		progWords.push_back(rFormat(FN_SLT, 7, 2, 1, 0));
		progWords.push_back(iFormat(OP_SW, 7, 0, 16'h0030));
		progWords.push_back(rFormat(FN_SLTU, 7, 2, 1, 0));
		progWords.push_back(iFormat(OP_SW, 7, 0, 16'h0034));
		progWords.push_back(rFormat(FN_SLL, 7, 0, 1, 4));
		progWords.push_back(iFormat(OP_SW, 7, 0, 16'h0038));
		progWords.push_back(rFormat(FN_SRL, 7, 0, 3, 4));
		progWords.push_back(iFormat(OP_SW, 7, 0, 16'h003C));
		progWords.push_back(rFormat(FN_SRA, 7, 0, 3, 4));
		progWords.push_back(iFormat(OP_SW, 7, 0, 16'h0040));
		progWords.push_back(iFormat(OP_SW, 1, 0, 16'h0080)); // Store, load back, use at once
		progWords.push_back(iFormat(OP_LW, 8, 0, 16'h0080));
		progWords.push_back(rFormat(FN_ADDU, 9, 8, 2, 0));
		progWords.push_back(iFormat(OP_SW, 9, 0, 16'h0044));
		progWords.push_back(iFormat(OP_BEQ, 1, 1, 16'h0001)); // Taken
		progWords.push_back(iFormat(OP_SW, 1, 0, 16'h0048));
		progWords.push_back(iFormat(OP_BNE, 1, 1, 16'h0001)); // Not taken
		progWords.push_back(iFormat(OP_SW, 6, 0, 16'h0048));
		progWords.push_back(jFormat(44));
		progWords.push_back(iFormat(OP_SW, 1, 0, 16'h004C));
		progWords.push_back(iFormat(OP_SW, 3, 0, 16'h004C));
		progWords.push_back(jFormat(45)); // Park here

		addExpected(32'h0000_0000, 32'h0000_1234);
		addExpected(32'h0000_0004, 32'hFFFF_FFFD);
		addExpected(32'h0000_0008, 32'h8000_0000);
		addExpected(32'h0000_000C, 32'h0000_F0F0);
		addExpected(32'h0000_0010, 32'hFFFF_7FFC);
		addExpected(32'h0000_0014, 32'h0000_0001);
		addExpected(32'h0000_0018, 32'h0000_1231);
		addExpected(32'h0000_001C, 32'h0000_1237);
		addExpected(32'h0000_0020, 32'h0000_70F0);
		addExpected(32'h0000_0024, 32'h8000_1234);
		addExpected(32'h0000_0028, 32'hFFFF_EDC9);
		addExpected(32'h0000_002C, 32'hFFFF_0D0B);
		addExpected(32'h0000_0030, 32'h0000_0001);
		addExpected(32'h0000_0034, 32'h0000_0000);
		addExpected(32'h0000_0038, 32'h0001_2340);
		addExpected(32'h0000_003C, 32'h0800_0000);
		addExpected(32'h0000_0040, 32'hF800_0000);
		addExpected(32'h0000_0080, 32'h0000_1234);
		addExpected(32'h0000_0044, 32'h0000_1231);
		addExpected(32'h0000_0048, 32'h0000_0001);
		addExpected(32'h0000_004C, 32'h8000_0000);

		cycleLimit = 40 * progWords.size();
		for (int i = 0; i < MEM_DEPTH; i++) begin
			if (i < progWords.size())
				memModel.loadRom(i, progWords[i]);
			else
				memModel.loadRom(i, 32'h0000_0000);
		end

		repeat (8) @(posedge Clk);
		rstN <= 1'b1;

		for (int k = 0; k < expAdr.size(); k++) begin
			do
				@(posedge Clk);
			while (!storeSeen);
			assert (storeAdr == expAdr[k]) else begin
				$display("mismatch storeAdr: got %h, expected %h (store %0d)", storeAdr, expAdr[k], k);
				mismatchCount++;
			end
			assert (storeDat == expDat[k]) else begin
				$display("mismatch storeDat: got %h, expected %h (store %0d)", storeDat, expDat[k], k);
				mismatchCount++;
			end
		end
		repeat (TAIL_CYCLES) @(posedge Clk);
		assert (storeTotal == expAdr.size()) else begin
			$display("wrong number of stores: %0d seen, %0d expected", storeTotal, expAdr.size());
			otherCount++;
		end

		$display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Bus watch, sees the values of the cycle that just ended
	always @(posedge Clk) begin
		if (!rstNQ) begin
			assert (!instCyc && !dataCyc) else begin
				$display("bus cycle active during or right at reset release");
				otherCount++;
			end
		end
		if (instOpenQ) begin
			assert (instAdr == instAdrQ) else begin
				$display("mismatch instAdr: got %h, expected %h", instAdr, instAdrQ);
				mismatchCount++;
			end
		end
		if (dataOpenQ) begin
			assert (dataAdr == dataAdrQ) else begin
				$display("mismatch dataAdr: got %h, expected %h", dataAdr, dataAdrQ);
				mismatchCount++;
			end
			assert (dataWrDat == dataWrDatQ) else begin
				$display("mismatch dataWrDat: got %h, expected %h", dataWrDat, dataWrDatQ);
				mismatchCount++;
			end
		end
		rstNQ <= rstN;
		instOpenQ <= instStb && !instAck;
		instAdrQ <= instAdr;
		dataOpenQ <= dataStb && !dataAck;
		dataAdrQ <= dataAdr;
		dataWrDatQ <= dataWrDat;
		if (storeSeen)
			storeTotal <= storeTotal + 1;
	end

	always @(posedge Clk) begin
		cycleCount <= cycleCount + 1;
		assert (cycleCount < cycleLimit) else begin
			$display("timeout: program did not finish");
			$display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount + 1);
			$display("sim failed");
			$finish;
		end
	end

endmodule

// ==== bench/wbMemory.sv ====
`timescale 1ns/1ns

module wbMemory #(parameter int DEPTH = 64) (
	input logic Clk,
	input logic rstN,
	input logic instCyc,
	input logic instStb,
	input logic [31:0] instAdr,
	output logic [31:0] instDatIn = 32'h0,
	output logic instAck = 1'b0,
	input logic dataCyc,
	input logic dataStb,
	input logic dataWe,
	input logic [31:0] dataAdr,
	input logic [31:0] dataWrDat,
	output logic [31:0] dataRdDat = 32'h0,
	output logic dataAck = 1'b0,
	output logic storeSeen = 1'b0,
	output logic [31:0] storeAdr = 32'h0,
	output logic [31:0] storeDat = 32'h0
);

	localparam int AW = $clog2(DEPTH);

	logic [31:0] rom [DEPTH];
	logic [31:0] ram [DEPTH];
	logic [31:0] rngState;
	logic instBusy;
	logic dataBusy;
	logic [1:0] instLeft; // Cycles until Ack
	logic [1:0] dataLeft;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic loadRom(input int idx, input logic [31:0] word);
		rom[idx] = word;
	endtask

	initial begin
		for (int i = 0; i < DEPTH; i++)
			ram[i] = {16'hDA7A, 16'(i << 2)}; // Word address in the low half
	end

	always @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			rngState = 32'ha1e0_8465;
			instBusy = 1'b0;
			dataBusy = 1'b0;
			instLeft = 2'd0;
			dataLeft = 2'd0;
			instAck <= 1'b0;
			dataAck <= 1'b0;
			storeSeen <= 1'b0;
		end else begin
			storeSeen <= 1'b0;
			if (instAck) begin
				instAck <= 1'b0;
				instBusy = 1'b0;
			end else if (instCyc && instStb) begin
				if (!instBusy) begin
					rngState = xorshift(rngState);
					instLeft = rngState[1:0];
					instBusy = 1'b1;
				end
				if (instLeft == 2'd0) begin
					instAck <= 1'b1;
					instDatIn <= rom[instAdr[AW+1:2]];
				end else
					instLeft = instLeft - 2'd1;
			end
			if (dataAck) begin
				dataAck <= 1'b0;
				dataBusy = 1'b0;
			end else if (dataCyc && dataStb) begin
				if (!dataBusy) begin
					rngState = xorshift(rngState);
					dataLeft = rngState[1:0];
					dataBusy = 1'b1;
				end
				if (dataLeft == 2'd0) begin
					dataAck <= 1'b1;
					if (dataWe) begin
						ram[dataAdr[AW+1:2]] <= dataWrDat;
						storeSeen <= 1'b1; // Hand the store to the checker
						storeAdr <= dataAdr;
						storeDat <= dataWrDat;
					end else
						dataRdDat <= ram[dataAdr[AW+1:2]];
				end else
					dataLeft = dataLeft - 2'd1;
			end
		end
	end

endmodule

// ==== build.f ====
+incdir+logic
logic/corePkg.sv
logic/pipeLink.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/mipsCore.sv
bench/wbMemory.sv
bench/coreTb.sv

// ==== logic/corePkg.sv ====
`include "core_settings.svh"

package corePkg;

	typedef logic [`XLEN-1:0] wordT;
	typedef logic [4:0] regIdxT;

	typedef enum logic [5:0] {
		opSpecial = 6'd0,
		opJ       = 6'd2,
		opBeq     = 6'd4,
		opBne     = 6'd5,
		opAddiu   = 6'd9,
		opSlti    = 6'd10,
		opAndi    = 6'd12,
		opOri     = 6'd13,
		opXori    = 6'd14,
		opLui     = 6'd15,
		opLw      = 6'd35,
		opSw      = 6'd43
	} opcodeT;

	typedef enum logic [5:0] {
		fnSll  = 6'd0,
		fnSrl  = 6'd2,
		fnSra  = 6'd3,
		fnAdd  = 6'd32, // Treated as ADDU
		fnAddu = 6'd33,
		fnSub  = 6'd34, // Treated as SUBU
		fnSubu = 6'd35,
		fnAnd  = 6'd36,
		fnOr   = 6'd37,
		fnXor  = 6'd38,
		fnNor  = 6'd39,
		fnSlt  = 6'd42,
		fnSltu = 6'd43
	} functT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
	} aluOpT;

	typedef struct packed {
		wordT pc;
		wordT instr;
	} fetchPayloadT;

	typedef struct packed {
		wordT pc;
		aluOpT aluOp;
		wordT opA;
		wordT opB;
		wordT storeData;
		wordT branchTarget; // Offset for branches, field for J
		regIdxT destReg;
		logic writes;
		logic isLoad;
		logic isStore;
		logic isBeq;
		logic isBne;
		logic isJump;
	} decodePayloadT;

	typedef struct packed {
		wordT result; // Also the load/store address
		wordT storeData;
		regIdxT destReg;
		logic writes;
		logic isLoad;
		logic isStore;
	} execPayloadT;

endpackage

// ==== logic/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data and address width
`define XLEN 32

// General registers, r0 reads zero
`define REG_COUNT 32

// First fetch address
`define RESET_PC 32'h0000_0000

// One pending bit per register
`define SCOREBOARD_SIZE 32

`endif

// ==== logic/decodeStage.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module decodeStage (
	input logic Clk,
	input logic rstN,
	pipeLink.consumer in,
	pipeLink.producer out,
	input logic redirect,
	input logic wbEn,
	input corePkg::regIdxT wbReg,
	input corePkg::wordT wbData
);

	corePkg::wordT regs [`REG_COUNT];
	corePkg::wordT instr, rsVal, rtVal, simm, zimm;
	corePkg::regIdxT rs, rt, rd;
	corePkg::opcodeT opcode;
	corePkg::functT funct;
	corePkg::decodePayloadT dec;
	logic [`SCOREBOARD_SIZE-1:0] pending, pendNow, clrMask, setMask;
	logic useRs, useRt, stall, outFree, issue;

	assign instr = in.payload.instr;
	assign opcode = corePkg::opcodeT'(instr[31:26]);
	assign funct = corePkg::functT'(instr[5:0]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign simm = {{(`XLEN-16){instr[15]}}, instr[15:0]};
	assign zimm = {{(`XLEN-16){1'b0}}, instr[15:0]};

	// Same-cycle write-back reads through
	assign rsVal = (rs == '0) ? '0 : (wbEn && wbReg == rs) ? wbData : regs[rs];
	assign rtVal = (rt == '0) ? '0 : (wbEn && wbReg == rt) ? wbData : regs[rt];

	always_ff @(posedge Clk) begin
		if (wbEn && wbReg != '0)
			regs[wbReg] <= wbData;
	end

	always_comb begin
		dec = '0;
		dec.pc = in.payload.pc;
		dec.aluOp = corePkg::aluAdd;
		dec.opA = rsVal;
		dec.opB = rtVal;
		dec.storeData = rtVal;
		dec.destReg = rt;
		useRs = 1'b0;
		useRt = 1'b0;
		if (instr != '0) begin // All-zero word is a NOP
			case (opcode)
				corePkg::opSpecial: begin
					dec.destReg = rd;
					dec.writes = 1'b1;
					useRs = 1'b1;
					useRt = 1'b1;
					case (funct)
						corePkg::fnSll, corePkg::fnSrl, corePkg::fnSra: begin
							dec.aluOp = (funct == corePkg::fnSll) ? corePkg::aluSll :
								(funct == corePkg::fnSrl) ? corePkg::aluSrl : corePkg::aluSra;
							dec.opA = rtVal;
							dec.opB = corePkg::wordT'(instr[10:6]); // shamt
							useRs = 1'b0;
						end
						corePkg::fnAdd, corePkg::fnAddu: dec.aluOp = corePkg::aluAdd;
						corePkg::fnSub, corePkg::fnSubu: dec.aluOp = corePkg::aluSub;
						corePkg::fnAnd: dec.aluOp = corePkg::aluAnd;
						corePkg::fnOr: dec.aluOp = corePkg::aluOr;
						corePkg::fnXor: dec.aluOp = corePkg::aluXor;
						corePkg::fnNor: dec.aluOp = corePkg::aluNor;
						corePkg::fnSlt: dec.aluOp = corePkg::aluSlt;
						corePkg::fnSltu: dec.aluOp = corePkg::aluSltu;
						default: dec.writes = 1'b0;
					endcase
				end
				corePkg::opAddiu, corePkg::opSlti, corePkg::opLw, corePkg::opSw: begin
					dec.aluOp = (opcode == corePkg::opSlti) ? corePkg::aluSlt : corePkg::aluAdd;
					dec.opB = simm;
					dec.writes = (opcode != corePkg::opSw);
					dec.isLoad = (opcode == corePkg::opLw);
					dec.isStore = (opcode == corePkg::opSw);
					useRs = 1'b1;
					useRt = (opcode == corePkg::opSw); // Store data
				end
				corePkg::opAndi, corePkg::opOri, corePkg::opXori, corePkg::opLui: begin
					dec.aluOp = (opcode == corePkg::opAndi) ? corePkg::aluAnd :
						(opcode == corePkg::opOri) ? corePkg::aluOr :
						(opcode == corePkg::opXori) ? corePkg::aluXor : corePkg::aluLui;
					dec.opB = zimm;
					dec.writes = 1'b1;
					useRs = (opcode != corePkg::opLui);
				end
				corePkg::opBeq, corePkg::opBne: begin
					dec.isBeq = (opcode == corePkg::opBeq);
					dec.isBne = (opcode == corePkg::opBne);
					dec.branchTarget = {simm[`XLEN-3:0], 2'b00};
					useRs = 1'b1;
					useRt = 1'b1;
				end
				corePkg::opJ: begin
					dec.isJump = 1'b1;
					dec.branchTarget = corePkg::wordT'({instr[25:0], 2'b00});
				end
				default: ;
			endcase
		end
		if (dec.destReg == '0)
			dec.writes = 1'b0;
	end

	// Scoreboard, a write-back this cycle already counts as done
	assign clrMask = wbEn ? (`SCOREBOARD_SIZE'(1) << wbReg) : '0;
	assign pendNow = pending & ~clrMask;
	assign setMask = (issue && dec.writes) ? (`SCOREBOARD_SIZE'(1) << dec.destReg) : '0;
	assign stall = (useRs && pendNow[rs]) || (useRt && pendNow[rt]) ||
		(dec.writes && pendNow[dec.destReg]);

	assign outFree = !out.valid || !out.hold;
	assign in.hold = !redirect && (stall || !outFree);
	assign issue = in.fire && !redirect; // Squashed word is just dropped

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			pending <= '0;
			out.valid <= 1'b0;
		end else begin
			pending <= pendNow | setMask;
			if (redirect)
				out.valid <= 1'b0;
			else if (outFree)
				out.valid <= issue;
		end
	end

	always_ff @(posedge Clk) begin
		if (issue)
			out.payload <= dec;
	end

	// Relies on memoryStage raising wbEn before the bit clears
	assert property (@(posedge Clk) disable iff (!rstN)
		issue |-> !(useRs && pending[rs] && !(wbEn && wbReg == rs)) &&
			!(useRt && pending[rt] && !(wbEn && wbReg == rt)));

endmodule

// ==== logic/executeStage.sv ====
`timescale 1ns/1ns

module executeStage (
	input logic Clk,
	input logic rstN,
	pipeLink.consumer in,
	pipeLink.producer out,
	output logic redirect,
	output corePkg::wordT redirectPc
);

	localparam int W = $bits(corePkg::wordT);

	corePkg::wordT a, b, result, pcPlus4;
	logic taken, isCtl;

	assign a = in.payload.opA;
	assign b = in.payload.opB;
	assign pcPlus4 = in.payload.pc + 4;

	always_comb begin
		case (in.payload.aluOp)
			corePkg::aluAdd: result = a + b;
			corePkg::aluSub: result = a - b;
			corePkg::aluAnd: result = a & b;
			corePkg::aluOr: result = a | b;
			corePkg::aluXor: result = a ^ b;
			corePkg::aluNor: result = ~(a | b);
			corePkg::aluSlt: result = corePkg::wordT'($signed(a) < $signed(b));
			corePkg::aluSltu: result = corePkg::wordT'(a < b);
			corePkg::aluSll: result = a << b[4:0];
			corePkg::aluSrl: result = a >> b[4:0];
			corePkg::aluSra: result = $signed(a) >>> b[4:0];
			corePkg::aluLui: result = {b[15:0], 16'h0000};
			default: result = a + b;
		endcase
	end

	assign isCtl = in.payload.isBeq || in.payload.isBne || in.payload.isJump;
	assign taken = in.payload.isJump || (in.payload.isBeq && a == b) ||
		(in.payload.isBne && a != b);

	assign redirect = in.fire && taken;
	assign redirectPc = in.payload.isJump ?
		{pcPlus4[W-1:W-4], in.payload.branchTarget[W-5:0]} :
		pcPlus4 + in.payload.branchTarget;

	assign in.hold = out.valid && out.hold;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			out.valid <= 1'b0;
		else if (!in.hold)
			out.valid <= in.valid && !isCtl; // Branches retire here
	end

	always_ff @(posedge Clk) begin
		if (in.fire) begin
			out.payload.result <= result;
			out.payload.storeData <= in.payload.storeData;
			out.payload.destReg <= in.payload.destReg;
			out.payload.writes <= in.payload.writes;
			out.payload.isLoad <= in.payload.isLoad;
			out.payload.isStore <= in.payload.isStore;
		end
	end

	// Decode squashes its slot, so back-to-back redirects cannot happen
	assert property (@(posedge Clk) disable iff (!rstN) redirect |=> !redirect);

endmodule

// ==== logic/fetchStage.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module fetchStage (
	input logic Clk,
	input logic rstN,
	input logic redirect,
	input corePkg::wordT redirectPc,
	output logic instCyc,
	output logic instStb,
	output corePkg::wordT instAdr,
	input corePkg::wordT instDatIn,
	input logic instAck,
	pipeLink.producer out
);

	corePkg::wordT pc; // Next fetch address
	logic discard; // Open request went stale
	logic outFree;
	logic acceptWord;

	assign outFree = !out.valid || !out.hold;
	assign acceptWord = instCyc && instAck && !discard && !redirect;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			pc <= `RESET_PC;
			instAdr <= `RESET_PC;
			instCyc <= 1'b0;
			instStb <= 1'b0;
			discard <= 1'b0;
			out.valid <= 1'b0;
		end else begin
			if (out.fire)
				out.valid <= 1'b0;
			if (instCyc) begin
				if (instAck) begin
					instCyc <= 1'b0;
					instStb <= 1'b0;
					discard <= 1'b0;
					if (acceptWord) begin
						out.valid <= 1'b1;
						pc <= instAdr + 4;
					end
				end else if (redirect) begin
					discard <= 1'b1; // Let it finish, drop the word
				end
			end else if (outFree && !redirect) begin
				instCyc <= 1'b1;
				instStb <= 1'b1;
				instAdr <= pc;
			end
			if (redirect)
				pc <= redirectPc;
		end
	end

	always_ff @(posedge Clk) begin
		if (acceptWord) begin
			out.payload.pc <= instAdr;
			out.payload.instr <= instDatIn;
		end
	end

	assert property (@(posedge Clk) disable iff (!rstN) instCyc |-> instAdr[1:0] == 2'b00);
	assert property (@(posedge Clk) disable iff (!rstN) instStb |-> instCyc);

endmodule

// ==== logic/memoryStage.sv ====
`timescale 1ns/1ns

module memoryStage (
	input logic Clk,
	input logic rstN,
	pipeLink.consumer in,
	output logic dataCyc,
	output logic dataStb,
	output logic dataWe,
	output corePkg::wordT dataAdr,
	output corePkg::wordT dataWrDat,
	input corePkg::wordT dataRdDat,
	input logic dataAck,
	output logic wbEn,
	output corePkg::regIdxT wbReg,
	output corePkg::wordT wbData
);

	logic isMem;
	logic busDone;

	assign isMem = in.payload.isLoad || in.payload.isStore;
	assign busDone = dataCyc && dataAck;

	// Memory ops wait for Ack, the rest go straight through
	assign in.hold = in.valid && isMem && !busDone;

	// Held link keeps these stable for the whole cycle
	assign dataAdr = in.payload.result;
	assign dataWrDat = in.payload.storeData;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			dataCyc <= 1'b0;
			dataStb <= 1'b0;
			dataWe <= 1'b0;
		end else if (dataCyc) begin
			if (dataAck) begin
				dataCyc <= 1'b0;
				dataStb <= 1'b0;
				dataWe <= 1'b0;
			end
		end else if (in.valid && isMem) begin
			dataCyc <= 1'b1;
			dataStb <= 1'b1;
			dataWe <= in.payload.isStore;
		end
	end

	assign wbEn = in.fire && in.payload.writes;
	assign wbReg = in.payload.destReg;
	assign wbData = in.payload.isLoad ? dataRdDat : in.payload.result; // Ack-cycle data

	assert property (@(posedge Clk) disable iff (!rstN) dataStb |-> dataCyc);
	assert property (@(posedge Clk) disable iff (!rstN)
		dataStb && !dataAck |=> $stable(dataAdr) && $stable(dataWrDat));

endmodule

// ==== logic/mipsCore.sv ====
`timescale 1ns/1ns

module mipsCore (
	input logic Clk,
	input logic rstN,
	output logic instCyc,
	output logic instStb,
	output corePkg::wordT instAdr,
	input corePkg::wordT instDatIn,
	input logic instAck,
	output logic dataCyc,
	output logic dataStb,
	output logic dataWe,
	output corePkg::wordT dataAdr,
	output corePkg::wordT dataWrDat,
	input corePkg::wordT dataRdDat,
	input logic dataAck
);

	logic redirect;
	corePkg::wordT redirectPc;
	logic wbEn;
	corePkg::regIdxT wbReg;
	corePkg::wordT wbData;

	pipeLink #(.payloadT(corePkg::fetchPayloadT)) fetchToDecode ();
	pipeLink #(.payloadT(corePkg::decodePayloadT)) decodeToExec ();
	pipeLink #(.payloadT(corePkg::execPayloadT)) execToMem ();

	fetchStage fetchStage_inst (
		.Clk(Clk),
		.rstN(rstN),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.instCyc(instCyc),
		.instStb(instStb),
		.instAdr(instAdr),
		.instDatIn(instDatIn),
		.instAck(instAck),
		.out(fetchToDecode.producer)
	);

	decodeStage decodeStage_inst (
		.Clk(Clk),
		.rstN(rstN),
		.in(fetchToDecode.consumer),
		.out(decodeToExec.producer),
		.redirect(redirect),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	executeStage executeStage_inst (
		.Clk(Clk),
		.rstN(rstN),
		.in(decodeToExec.consumer),
		.out(execToMem.producer),
		.redirect(redirect),
		.redirectPc(redirectPc)
	);

	memoryStage memoryStage_inst (
		.Clk(Clk),
		.rstN(rstN),
		.in(execToMem.consumer),
		.dataCyc(dataCyc),
		.dataStb(dataStb),
		.dataWe(dataWe),
		.dataAdr(dataAdr),
		.dataWrDat(dataWrDat),
		.dataRdDat(dataRdDat),
		.dataAck(dataAck),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData)
	);

endmodule

// ==== logic/pipeLink.sv ====
`timescale 1ns/1ns

// One stage boundary, transfer on valid && !hold
interface pipeLink #(parameter type payloadT = logic) ();

	logic valid;
	logic hold;
	logic fire;
	payloadT payload;

	assign fire = valid && !hold;

	modport producer (
		output valid,
		output payload,
		input hold,
		input fire
	);

	modport consumer (
		input valid,
		input payload,
		input fire,
		output hold
	);

endinterface
